//--- design/exec_pkg.sv
package exec_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int ram_words = 256;
    localparam int ram_addr_w = 8;
    localparam int wait_cnt_w = 8;

    // alu control codes, sub and the two compares also resolve branches
    localparam int alu_op_w = 4;
    localparam logic [alu_op_w-1:0] alu_add = 4'b0000;
    localparam logic [alu_op_w-1:0] alu_sub = 4'b0001;
    localparam logic [alu_op_w-1:0] alu_and = 4'b0010;
    localparam logic [alu_op_w-1:0] alu_or = 4'b0011;
    localparam logic [alu_op_w-1:0] alu_sltu = 4'b0100;
    localparam logic [alu_op_w-1:0] alu_slt = 4'b0101;
    localparam logic [alu_op_w-1:0] alu_xor = 4'b0110;
    localparam logic [alu_op_w-1:0] alu_sll = 4'b0111;
    localparam logic [alu_op_w-1:0] alu_srl = 4'b1000;
    localparam logic [alu_op_w-1:0] alu_sra = 4'b1001;

    localparam int fwd_w = 2;
    localparam logic [fwd_w-1:0] fwd_reg = 2'b00;
    localparam logic [fwd_w-1:0] fwd_wb = 2'b01;
    localparam logic [fwd_w-1:0] fwd_mem = 2'b10;

    localparam int res_w = 2;
    localparam logic [res_w-1:0] res_alu = 2'b00;
    localparam logic [res_w-1:0] res_mem = 2'b01;
    localparam logic [res_w-1:0] res_pc4 = 2'b10;

    // memory fsm states
    localparam int st_w = 2;
    localparam logic [st_w-1:0] st_idle = 2'b00;
    localparam logic [st_w-1:0] st_bus = 2'b01;
    localparam logic [st_w-1:0] st_done = 2'b10;

    // alu result seen as a data word or as a ram address
    typedef union packed {
        logic [xlen-1:0] word;
        struct packed {
            logic [xlen-ram_addr_w-3:0] tag;
            logic [ram_addr_w-1:0] index;
            logic [1:0] offset;
        } addr;
    } exec_result_u;

endpackage

//--- design/alu.sv
`timescale 1ns/100ps

module alu (
    input  logic [exec_pkg::xlen-1:0]     a,
    input  logic [exec_pkg::xlen-1:0]     b,
    input  logic [exec_pkg::alu_op_w-1:0] alu_control,
    output logic [exec_pkg::xlen-1:0]     result,
    output logic                          zero
);

    always_comb begin
        case (alu_control)
            exec_pkg::alu_add: result = a + b;
            exec_pkg::alu_sub: result = a - b;
            exec_pkg::alu_and: result = a & b;
            exec_pkg::alu_or: result = a | b;
            exec_pkg::alu_xor: result = a ^ b;
            exec_pkg::alu_sll: result = a << b[4:0];
            exec_pkg::alu_srl: result = a >> b[4:0];
            // arithmetic shift keeps the sign
            exec_pkg::alu_sra: result = $signed(a) >>> b[4:0];
            exec_pkg::alu_sltu: result = {{(exec_pkg::xlen-1){1'b0}}, a < b};
            exec_pkg::alu_slt: result = {{(exec_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- design/exec_stage.sv
`timescale 1ns/100ps

module exec_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [exec_pkg::alu_op_w-1:0] alu_control,
    input  logic                          use_pc,
    input  logic                          alu_src,
    input  logic                          branch,
    input  logic                          jump,
    input  logic                          funct3_0,
    input  logic [exec_pkg::xlen-1:0]     rd1,
    input  logic [exec_pkg::xlen-1:0]     rd2,
    input  logic [exec_pkg::xlen-1:0]     imm_ext,
    input  logic [exec_pkg::xlen-1:0]     pc,
    input  logic [exec_pkg::fwd_w-1:0]    fwd_a,
    input  logic [exec_pkg::fwd_w-1:0]    fwd_b,
    input  logic [exec_pkg::xlen-1:0]     mem_fwd_data,
    input  logic [exec_pkg::xlen-1:0]     wb_fwd_data,
    output logic [exec_pkg::xlen-1:0]     alu_result,
    output logic [exec_pkg::xlen-1:0]     store_data,
    output logic                          pc_src,
    output logic [exec_pkg::xlen-1:0]     pc_target
);

    logic [exec_pkg::xlen-1:0] src_a_fwd;
    logic [exec_pkg::xlen-1:0] src_a;
    logic [exec_pkg::xlen-1:0] src_b;
    logic zero;
    logic branch_met;

    always_comb begin
        case (fwd_a)
            exec_pkg::fwd_wb: src_a_fwd = wb_fwd_data;
            exec_pkg::fwd_mem: src_a_fwd = mem_fwd_data;
            default: src_a_fwd = rd1;
        endcase
        case (fwd_b)
            exec_pkg::fwd_wb: store_data = wb_fwd_data;
            exec_pkg::fwd_mem: store_data = mem_fwd_data;
            default: store_data = rd2;
        endcase
    end

    assign src_a = use_pc ? pc : src_a_fwd;
    assign src_b = alu_src ? imm_ext : store_data;

    // load/store address is this result too, decoder picks add with imm
    alu u_alu (
        .a(src_a),
        .b(src_b),
        .alu_control(alu_control),
        .result(alu_result),
        .zero(zero)
    );

    alu u_target_adder (
        .a(pc),
        .b(imm_ext),
        .alu_control(exec_pkg::alu_add),
        .result(pc_target),
        .zero()
    );

    always_comb begin
        case (alu_control)
            exec_pkg::alu_sub: branch_met = funct3_0 ^ zero;
            exec_pkg::alu_slt, exec_pkg::alu_sltu: branch_met = funct3_0 ^ alu_result[0];
            default: branch_met = 1'b0;
        endcase
    end

    assign pc_src = (branch_met & branch) | jump;

    // hazard unit only produces three of the four codes
    assert property (@(posedge clk) disable iff (reset) (fwd_a != 2'b11) && (fwd_b != 2'b11));

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  logic [exec_pkg::reg_addr_w-1:0] rs1,
    input  logic [exec_pkg::reg_addr_w-1:0] rs2,
    input  logic                            in_valid,
    input  logic                            mem_valid,
    input  logic [exec_pkg::reg_addr_w-1:0] mem_rd,
    input  logic                            mem_reg_write,
    input  logic                            mem_is_load,
    input  logic                            wb_valid,
    input  logic [exec_pkg::reg_addr_w-1:0] wb_rd,
    input  logic                            wb_reg_write,
    output logic [exec_pkg::fwd_w-1:0]      fwd_a,
    output logic [exec_pkg::fwd_w-1:0]      fwd_b,
    output logic                            load_stall
);

    logic mem_writes;
    logic wb_writes;

    // x0 never forwards
    assign mem_writes = mem_valid && mem_reg_write && (mem_rd != '0);
    assign wb_writes = wb_valid && wb_reg_write && (wb_rd != '0);

    // mem stage wins over write-back; a load in mem stalls instead
    always_comb begin
        fwd_a = exec_pkg::fwd_reg;
        fwd_b = exec_pkg::fwd_reg;
        if (mem_writes && !mem_is_load && mem_rd == rs1) fwd_a = exec_pkg::fwd_mem;
        else if (wb_writes && wb_rd == rs1) fwd_a = exec_pkg::fwd_wb;
        if (mem_writes && !mem_is_load && mem_rd == rs2) fwd_b = exec_pkg::fwd_mem;
        else if (wb_writes && wb_rd == rs2) fwd_b = exec_pkg::fwd_wb;
    end

    assign load_stall = in_valid && mem_writes && mem_is_load && (mem_rd == rs1 || mem_rd == rs2);

endmodule

//--- design/mem_access_fsm.sv
`timescale 1ns/100ps

module mem_access_fsm (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            mem_valid,
    input  logic                            mem_read,
    input  logic                            mem_write,
    input  exec_pkg::exec_result_u          addr,
    input  logic [exec_pkg::xlen-1:0]       store_data,
    output logic                            mem_done,
    output logic [exec_pkg::xlen-1:0]       load_data,
    output logic                            misaligned_error,
    output logic                            cyc,
    output logic                            stb,
    output logic                            we,
    output logic [exec_pkg::ram_addr_w-1:0] adr,
    output logic [exec_pkg::xlen-1:0]       dat_w,
    output logic [3:0]                      sel,
    input  logic [exec_pkg::xlen-1:0]       dat_r,
    input  logic                            ack
);

    logic [exec_pkg::st_w-1:0] state;
    logic start;
    logic bad_addr;

    assign start = mem_valid && (mem_read || mem_write);
    assign bad_addr = (addr.addr.offset != '0) || (addr.addr.tag != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= exec_pkg::st_idle;
            misaligned_error <= 1'b0;
        end else begin
            case (state)
                exec_pkg::st_idle: begin
                    if (start && bad_addr) begin
                        misaligned_error <= 1'b1;
                        state <= exec_pkg::st_done;
                    end else if (start) begin
                        state <= exec_pkg::st_bus;
                    end
                end
                exec_pkg::st_bus: if (ack) state <= exec_pkg::st_done;
                default: state <= exec_pkg::st_idle;
            endcase
        end
    end

    // refused load reads back as zero
    always_ff @(posedge clk) begin
        if (state == exec_pkg::st_bus && ack) load_data <= dat_r;
        else if (state == exec_pkg::st_idle && start && bad_addr) load_data <= '0;
    end

    // bus fields come from the exec/mem register, held until done
    assign cyc = (state == exec_pkg::st_bus);
    assign stb = cyc;
    assign we = mem_write;
    assign adr = addr.addr.index;
    assign dat_w = store_data;
    assign sel = 4'hf;
    assign mem_done = (state == exec_pkg::st_done);

    // cycle ends right after ack
    assert property (@(posedge clk) disable iff (reset) ack |=> !cyc);
    assert property (@(posedge clk) disable iff (reset) stb && !ack |=> $stable(adr));

endmodule

//--- design/wb_data_ram.sv
`timescale 1ns/100ps

module wb_data_ram #(
    parameter int WAIT_STATES = 1
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  logic [exec_pkg::ram_addr_w-1:0] adr,
    input  logic [exec_pkg::xlen-1:0]       dat_w,
    input  logic [3:0]                      sel,
    output logic [exec_pkg::xlen-1:0]       dat_r,
    output logic                            ack
);

    logic [exec_pkg::xlen-1:0] mem [exec_pkg::ram_words];
    logic [exec_pkg::wait_cnt_w-1:0] wait_cnt;

    // ack is one cycle, WAIT_STATES cycles after stb rises
    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            wait_cnt <= '0;
        end else if (cyc && stb && !ack) begin
            ack <= (wait_cnt == exec_pkg::wait_cnt_w'(WAIT_STATES - 1));
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            ack <= 1'b0;
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (cyc && stb && !ack) dat_r <= mem[adr];
        if (ack && we) begin
            for (int i = 0; i < 4; i++) begin
                if (sel[i]) mem[adr][8*i +: 8] <= dat_w[8*i +: 8];
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) ack |-> stb);

endmodule

//--- design/perf_counters.sv
`timescale 1ns/100ps

module perf_counters (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      retire,
    input  logic                      taken,
    output logic [exec_pkg::xlen-1:0] instret,
    output logic [exec_pkg::xlen-1:0] branches_taken
);

    // both stop at all ones
    always_ff @(posedge clk) begin
        if (reset) begin
            instret <= '0;
            branches_taken <= '0;
        end else begin
            if (retire && instret != '1) instret <= instret + 1'b1;
            if (taken && branches_taken != '1) branches_taken <= branches_taken + 1'b1;
        end
    end

endmodule

//--- design/exec_mem_top.sv
`timescale 1ns/100ps

module exec_mem_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [exec_pkg::alu_op_w-1:0]   alu_control,
    input  logic                            use_pc,
    input  logic                            alu_src,
    input  logic                            branch,
    input  logic                            jump,
    input  logic                            funct3_0,
    input  logic                            mem_write,
    input  logic                            mem_read,
    input  logic                            reg_write,
    input  logic [exec_pkg::res_w-1:0]      result_src,
    input  logic [exec_pkg::reg_addr_w-1:0] rs1,
    input  logic [exec_pkg::reg_addr_w-1:0] rs2,
    input  logic [exec_pkg::reg_addr_w-1:0] rd,
    input  logic [exec_pkg::xlen-1:0]       rd1,
    input  logic [exec_pkg::xlen-1:0]       rd2,
    input  logic [exec_pkg::xlen-1:0]       imm_ext,
    input  logic [exec_pkg::xlen-1:0]       pc,
    input  logic [exec_pkg::xlen-1:0]       pc_plus4,
    output logic                            pc_src,
    output logic [exec_pkg::xlen-1:0]       pc_target,
    output logic                            wb_valid,
    output logic                            wb_we,
    output logic [exec_pkg::reg_addr_w-1:0] wb_rd,
    output logic [exec_pkg::xlen-1:0]       wb_data,
    output logic                            misaligned_error,
    output logic [exec_pkg::xlen-1:0]       instret,
    output logic [exec_pkg::xlen-1:0]       branches_taken
);

    logic [exec_pkg::fwd_w-1:0] fwd_a;
    logic [exec_pkg::fwd_w-1:0] fwd_b;
    logic load_stall;
    logic ready_q;
    logic [exec_pkg::xlen-1:0] alu_result_e;
    logic [exec_pkg::xlen-1:0] store_data_e;
    logic [exec_pkg::xlen-1:0] mem_fwd_data;

    // exec/mem register
    logic mem_valid;
    logic mem_reg_write;
    logic mem_rd_en;
    logic mem_wr_en;
    logic [exec_pkg::res_w-1:0] mem_result_src;
    logic [exec_pkg::reg_addr_w-1:0] mem_rd;
    exec_pkg::exec_result_u mem_alu_result;
    logic [exec_pkg::xlen-1:0] mem_store_data;
    logic [exec_pkg::xlen-1:0] mem_pc_plus4;

    logic mem_done;
    logic mem_busy;
    logic mem_advance;
    logic [exec_pkg::xlen-1:0] load_data;

    logic cyc;
    logic stb;
    logic we;
    logic [exec_pkg::ram_addr_w-1:0] adr;
    logic [exec_pkg::xlen-1:0] dat_w;
    logic [exec_pkg::xlen-1:0] dat_r;
    logic [3:0] sel;
    logic ack;

    assign mem_busy = mem_valid && (mem_rd_en || mem_wr_en) && !mem_done;
    assign mem_advance = mem_valid && !mem_busy;
    assign in_ready = ready_q && !mem_busy && !load_stall;

    // a jump in mem forwards its link address
    assign mem_fwd_data = (mem_result_src == exec_pkg::res_pc4) ? mem_pc_plus4
                                                                : mem_alu_result.word;

    hazard_unit u_hazard (
        .rs1(rs1),
        .rs2(rs2),
        .in_valid(in_valid),
        .mem_valid(mem_valid),
        .mem_rd(mem_rd),
        .mem_reg_write(mem_reg_write),
        .mem_is_load(mem_rd_en),
        .wb_valid(wb_valid),
        .wb_rd(wb_rd),
        .wb_reg_write(wb_we),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .load_stall(load_stall)
    );

    exec_stage u_exec (
        .clk(clk),
        .reset(reset),
        .alu_control(alu_control),
        .use_pc(use_pc),
        .alu_src(alu_src),
        .branch(branch),
        .jump(jump),
        .funct3_0(funct3_0),
        .rd1(rd1),
        .rd2(rd2),
        .imm_ext(imm_ext),
        .pc(pc),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .mem_fwd_data(mem_fwd_data),
        .wb_fwd_data(wb_data),
        .alu_result(alu_result_e),
        .store_data(store_data_e),
        .pc_src(pc_src),
        .pc_target(pc_target)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            if (in_ready) mem_valid <= in_valid;
            else if (mem_advance) mem_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            mem_reg_write <= reg_write;
            mem_rd_en <= mem_read;
            mem_wr_en <= mem_write;
            mem_result_src <= result_src;
            mem_rd <= rd;
            mem_alu_result.word <= alu_result_e;
            mem_store_data <= store_data_e;
            mem_pc_plus4 <= pc_plus4;
        end
    end

    mem_access_fsm u_mem_fsm (
        .clk(clk),
        .reset(reset),
        .mem_valid(mem_valid),
        .mem_read(mem_rd_en),
        .mem_write(mem_wr_en),
        .addr(mem_alu_result),
        .store_data(mem_store_data),
        .mem_done(mem_done),
        .load_data(load_data),
        .misaligned_error(misaligned_error),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .sel(sel),
        .dat_r(dat_r),
        .ack(ack)
    );

    wb_data_ram u_ram (
        .clk(clk),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .sel(sel),
        .dat_r(dat_r),
        .ack(ack)
    );

    // mem/wb register
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_we <= 1'b0;
        end else begin
            wb_valid <= mem_advance;
            wb_we <= mem_advance && mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_advance) begin
            wb_rd <= mem_rd;
            case (mem_result_src)
                exec_pkg::res_mem: wb_data <= load_data;
                exec_pkg::res_pc4: wb_data <= mem_pc_plus4;
                default: wb_data <= mem_alu_result.word;
            endcase
        end
    end

    perf_counters u_perf (
        .clk(clk),
        .reset(reset),
        .retire(wb_valid),
        .taken(pc_src && in_valid && in_ready),
        .instret(instret),
        .branches_taken(branches_taken)
    );

endmodule

//--- sim/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// expected alu output, written from the rv32i rules
function automatic logic [exec_pkg::xlen-1:0] alu_ref(
    input logic [exec_pkg::alu_op_w-1:0] op,
    input logic [exec_pkg::xlen-1:0]     a,
    input logic [exec_pkg::xlen-1:0]     b
);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        exec_pkg::alu_add: return a + b;
        exec_pkg::alu_sub: return a - b;
        exec_pkg::alu_and: return a & b;
        exec_pkg::alu_or: return a | b;
        exec_pkg::alu_xor: return a ^ b;
        exec_pkg::alu_sll: return a << sh;
        exec_pkg::alu_srl: return a >> sh;
        // fill the vacated top bits with the sign
        exec_pkg::alu_sra: return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        exec_pkg::alu_sltu: return {31'b0, a < b};
        // flipping the sign bits turns a signed compare into an unsigned one
        exec_pkg::alu_slt: return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
        default: return 32'h0;
    endcase
endfunction

// beq/bne from sub, blt/bge from slt, bltu/bgeu from sltu
function automatic logic branch_ref(
    input logic [exec_pkg::alu_op_w-1:0] op,
    input logic [exec_pkg::xlen-1:0]     a,
    input logic [exec_pkg::xlen-1:0]     b,
    input logic                          f3_0,
    input logic                          is_branch,
    input logic                          is_jump
);
    logic cond;
    case (op)
        exec_pkg::alu_sub: cond = f3_0 ^ (a == b);
        exec_pkg::alu_sltu: cond = f3_0 ^ (a < b);
        exec_pkg::alu_slt: cond = f3_0 ^ ($signed(a) < $signed(b));
        default: cond = 1'b0;
    endcase
    return (is_branch & cond) | is_jump;
endfunction

task automatic report_mismatch(
    input string       name,
    input logic [31:0] expected,
    input logic [31:0] actual
);
    value_errors++;
    $display("Fail at time %0t: %s expected %h actual %h", $time, name, expected, actual);
endtask

task automatic check_wb(
    input logic                            exp_we,
    input logic [exec_pkg::reg_addr_w-1:0] exp_rd,
    input logic [exec_pkg::xlen-1:0]       exp_data,
    input logic                            exp_err
);
    if (wb_we !== exp_we) report_mismatch("wb_we", 32'(exp_we), 32'(wb_we));
    if (exp_we && wb_rd !== exp_rd) report_mismatch("wb_rd", 32'(exp_rd), 32'(wb_rd));
    if (exp_we && wb_data !== exp_data) report_mismatch("wb_data", exp_data, wb_data);
    if (misaligned_error !== exp_err) begin
        report_mismatch("misaligned_error", 32'(exp_err), 32'(misaligned_error));
    end
endtask

task automatic check_branch(
    input logic                      exp_src,
    input logic [exec_pkg::xlen-1:0] exp_target
);
    if (pc_src !== exp_src) report_mismatch("pc_src", 32'(exp_src), 32'(pc_src));
    if (pc_target !== exp_target) report_mismatch("pc_target", exp_target, pc_target);
endtask

task automatic check_count(
    input string                     name,
    input logic [exec_pkg::xlen-1:0] expected,
    input logic [exec_pkg::xlen-1:0] actual
);
    if (actual !== expected) report_mismatch(name, expected, actual);
endtask

`endif

//--- sim/tb_exec_mem.sv
`timescale 1ns/100ps

module tb_exec_mem;

    localparam int n_ops = 400;
    localparam int wait_states = 1;
    localparam int clk_period = 20;
    localparam int watchdog_cycles = n_ops * (wait_states + 4) + 200;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    logic [exec_pkg::alu_op_w-1:0] alu_control;
    logic use_pc;
    logic alu_src;
    logic branch;
    logic jump;
    logic funct3_0;
    logic mem_write;
    logic mem_read;
    logic reg_write;
    logic [exec_pkg::res_w-1:0] result_src;
    logic [exec_pkg::reg_addr_w-1:0] rs1;
    logic [exec_pkg::reg_addr_w-1:0] rs2;
    logic [exec_pkg::reg_addr_w-1:0] rd;
    logic [exec_pkg::xlen-1:0] rd1;
    logic [exec_pkg::xlen-1:0] rd2;
    logic [exec_pkg::xlen-1:0] imm_ext;
    logic [exec_pkg::xlen-1:0] pc;
    logic [exec_pkg::xlen-1:0] pc_plus4;
    logic pc_src;
    logic [exec_pkg::xlen-1:0] pc_target;
    logic wb_valid;
    logic wb_we;
    logic [exec_pkg::reg_addr_w-1:0] wb_rd;
    logic [exec_pkg::xlen-1:0] wb_data;
    logic misaligned_error;
    logic [exec_pkg::xlen-1:0] instret;
    logic [exec_pkg::xlen-1:0] branches_taken;

    int seed = 90413;
    int value_errors;
    int other_errors;
    int accepted;
    int presented;
    int ref_taken;
    logic accept_seen;
    logic ref_err;
    logic [exec_pkg::xlen-1:0] next_pc;

    // rf feeds rd1/rd2 from the dut write-back, ref_regs is the model state
    logic [exec_pkg::xlen-1:0] rf [32];
    logic [exec_pkg::xlen-1:0] ref_regs [32];
    logic [exec_pkg::xlen-1:0] ref_mem [exec_pkg::ram_words];
    logic written [exec_pkg::ram_words];

    logic exp_we_q [$];
    logic [exec_pkg::reg_addr_w-1:0] exp_rd_q [$];
    logic [exec_pkg::xlen-1:0] exp_data_q [$];
    logic exp_err_q [$];

    `include "tb_ref_model.svh"

    exec_mem_top u_dut (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic print_error_counts();
        $display("error count: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
    endtask

    task automatic make_op();
        int kind;
        int idx;
        kind = $unsigned($random(seed)) % 16;
        idx = $unsigned($random(seed)) % 16;
        alu_control = exec_pkg::alu_add;
        use_pc = 1'b0;
        alu_src = 1'b1;
        branch = 1'b0;
        jump = 1'b0;
        funct3_0 = 1'($random(seed));
        mem_write = 1'b0;
        mem_read = 1'b0;
        reg_write = 1'b1;
        result_src = exec_pkg::res_alu;
        // few registers, so neighbours depend on each other often
        rs1 = 5'($unsigned($random(seed)) % 8);
        rs2 = 5'($unsigned($random(seed)) % 8);
        rd = 5'($unsigned($random(seed)) % 8);
        imm_ext = $random(seed);
        pc = next_pc;
        pc_plus4 = next_pc + 32'd4;
        next_pc = next_pc + 32'd4;
        // loads only hit stored words, otherwise store first
        if ((kind == 10 || kind == 11) && !written[idx]) kind = 7;
        if (kind < 4) begin
            alu_control = 4'($unsigned($random(seed)) % 10);
            alu_src = 1'b0;
        end else if (kind < 7) begin
            alu_control = 4'($unsigned($random(seed)) % 10);
            use_pc = 1'($random(seed));
        end else if (kind < 10) begin
            rs1 = '0;
            imm_ext = 32'(idx * 4);
            mem_write = 1'b1;
            reg_write = 1'b0;
        end else if (kind < 12) begin
            rs1 = '0;
            imm_ext = 32'(idx * 4);
            mem_read = 1'b1;
            result_src = exec_pkg::res_mem;
        end else if (kind < 14) begin
            case ($unsigned($random(seed)) % 3)
                0: alu_control = exec_pkg::alu_sub;
                1: alu_control = exec_pkg::alu_sltu;
                default: alu_control = exec_pkg::alu_slt;
            endcase
            alu_src = 1'b0;
            branch = 1'b1;
            reg_write = 1'b0;
        end else if (kind == 14) begin
            use_pc = 1'b1;
            jump = 1'b1;
            result_src = exec_pkg::res_pc4;
        end else begin
            // refused access, odd byte offset or above the ram
            rs1 = '0;
            imm_ext = 32'(idx * 4) + (funct3_0 ? 32'h0000_1000 : 32'd2);
            mem_read = 1'($random(seed));
            mem_write = !mem_read;
            reg_write = mem_read;
            result_src = exec_pkg::res_mem;
        end
    endtask

    // runs one accepted micro-op in program order
    task automatic predict_accepted();
        logic [exec_pkg::xlen-1:0] a;
        logic [exec_pkg::xlen-1:0] b;
        logic [exec_pkg::xlen-1:0] result;
        logic [exec_pkg::xlen-1:0] wdata;
        logic taken;
        a = use_pc ? pc : ref_regs[rs1];
        b = alu_src ? imm_ext : ref_regs[rs2];
        result = alu_ref(alu_control, a, b);
        taken = branch_ref(alu_control, a, b, funct3_0, branch, jump);
        check_branch(taken, pc + imm_ext);
        if (taken) ref_taken++;
        wdata = result;
        if ((mem_read || mem_write) && (result[1:0] != 2'b00 || result[31:10] != '0)) begin
            ref_err = 1'b1;
            wdata = '0;
        end else if (mem_write) begin
            ref_mem[result[9:2]] = ref_regs[rs2];
            written[result[9:2]] = 1'b1;
        end else if (mem_read) begin
            wdata = ref_mem[result[9:2]];
        end
        if (result_src == exec_pkg::res_pc4) wdata = pc_plus4;
        exp_we_q.push_back(reg_write);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(wdata);
        exp_err_q.push_back(ref_err);
        if (reg_write && rd != '0) ref_regs[rd] = wdata;
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (wb_valid) begin
                if (exp_data_q.size() == 0) begin
                    other_errors++;
                    $display("write-back at time %0t with no micro-op outstanding", $time);
                end else begin
                    check_wb(exp_we_q.pop_front(), exp_rd_q.pop_front(),
                             exp_data_q.pop_front(), exp_err_q.pop_front());
                end
                if (wb_we && wb_rd != '0) rf[wb_rd] = wb_data;
            end
            if (in_valid && in_ready) begin
                predict_accepted();
                accepted++;
                accept_seen = 1'b1;
            end
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        alu_control = exec_pkg::alu_add;
        use_pc = 1'b0;
        alu_src = 1'b0;
        branch = 1'b0;
        jump = 1'b0;
        funct3_0 = 1'b0;
        mem_write = 1'b0;
        mem_read = 1'b0;
        reg_write = 1'b0;
        result_src = exec_pkg::res_alu;
        rs1 = '0;
        rs2 = '0;
        rd = '0;
        rd1 = '0;
        rd2 = '0;
        imm_ext = '0;
        pc = '0;
        pc_plus4 = '0;
        accept_seen = 1'b0;
        ref_err = 1'b0;
        next_pc = 32'h0000_0100;
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
            ref_regs[i] = '0;
        end
        for (int i = 0; i < exec_pkg::ram_words; i++) written[i] = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // in_ready low for the first cycle out of reset
        if (in_ready !== 1'b0) report_mismatch("in_ready", 32'h0, 32'(in_ready));
        if (wb_valid !== 1'b0) report_mismatch("wb_valid", 32'h0, 32'(wb_valid));
        if (misaligned_error !== 1'b0) begin
            report_mismatch("misaligned_error", 32'h0, 32'(misaligned_error));
        end
        check_count("instret", '0, instret);
        check_count("branches_taken", '0, branches_taken);
        while (accepted < n_ops) begin
            @(negedge clk);
            if (!in_valid || accept_seen) begin
                accept_seen = 1'b0;
                if (presented < n_ops && ($unsigned($random(seed)) % 8) != 0) begin
                    make_op();
                    presented++;
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            // read ports follow the latest write-back
            rd1 = rf[rs1];
            rd2 = rf[rs2];
        end
        while (exp_data_q.size() != 0) @(negedge clk);
        @(negedge clk);
        check_count("instret", 32'(n_ops), instret);
        check_count("branches_taken", 32'(ref_taken), branches_taken);
        print_error_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        other_errors++;
        $display("watchdog expired after %0d cycles, %0d of %0d micro-ops accepted",
                 watchdog_cycles, accepted, n_ops);
        print_error_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+sim
design/exec_pkg.sv
design/alu.sv
design/exec_stage.sv
design/hazard_unit.sv
design/mem_access_fsm.sv
design/wb_data_ram.sv
design/perf_counters.sv
design/exec_mem_top.sv
sim/tb_exec_mem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the exec/mem testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_exec_mem -f flist.f -Mdir "$build_dir" -o tb_exec_mem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_exec_mem" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    exit 1
fi
exit 0
